//--- int_div_iterative.f
src/div_pkg.sv
src/div_req_stage.sv
src/div_iter_ctrl.sv
src/div_iter_dpath.sv
src/div_resp_stage.sv
src/int_div_iterative.sv
testbench/int_div_tb.sv

//--- Bender.yml
package:
  name: int_div_iterative

sources:
  # package first, then the submodules, then the top level
  - src/div_pkg.sv
  - src/div_req_stage.sv
  - src/div_iter_ctrl.sv
  - src/div_iter_dpath.sv
  - src/div_resp_stage.sv
  - src/int_div_iterative.sv

  - target: test
    files:
      - testbench/int_div_tb.sv

export_include_dirs: []

dependencies: {}

//--- testbench/int_div_tb.sv
// self-checking testbench for int_div_iterative; inputs change on the falling clock edge
// expected results come from a behavioral model queued at each request transfer
`timescale 1ns/1ps

module int_div_tb;

  localparam int CLK_PERIOD = 20;
  localparam int N_RAND = 40;
  // random requests of two tests plus room for every directed one
  localparam int N_REQ = 2 * N_RAND + 30;
  localparam longint WATCHDOG_NS = longint'(N_REQ * 60 + 500) * CLK_PERIOD;
  // resp_rdy patterns
  localparam int RDY_ALWAYS = 0;
  localparam int RDY_RANDOM = 1;
  localparam int RDY_HOLD = 2;

  logic              clk;
  logic              reset;
  div_pkg::div_fn_t  req_fn;
  div_pkg::operand_t req_a;
  div_pkg::operand_t req_b;
  logic              req_val;
  logic              req_rdy;
  div_pkg::result_t  resp_result;
  logic              resp_val;
  logic              resp_rdy;

  // scoreboard state updated on the rising edge only
  div_pkg::result_t exp_q[$];
  int               cyc_q[$];
  div_pkg::result_t exp_head;
  int               head_cycle;
  int               exp_count;
  int               max_depth;
  int               cycle;
  int               req_count;
  int               resp_count;
  int               err_count = 0;
  int               tests_done = 0;
  int               rdy_mode;
  logic [31:0]      stim_lfsr = 32'haa97;
  logic [31:0]      rdy_lfsr = 32'haa97;

  int_div_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // --------------------------------------------------
  // random source and reference model
  // --------------------------------------------------

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic div_pkg::operand_t rand_word(input int nbits);
    div_pkg::operand_t w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      w = {w[30:0], stim_lfsr[0]};
    end
    return w;
  endfunction

  // truncating division with the remainder taking the dividend sign
  function automatic div_pkg::result_t ref_result(input div_pkg::div_fn_t fn,
                                                  input div_pkg::operand_t a,
                                                  input div_pkg::operand_t b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    if (b == '0) begin
      return {a, 32'hffff_ffff};
    end
    if (fn == div_pkg::FN_SIGNED && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return {32'h0, 32'h8000_0000};
    end
    if (fn == div_pkg::FN_SIGNED) begin
      sa = $signed(a);
      sb = $signed(b);
    end else begin
      sa = {32'h0, a};
      sb = {32'h0, b};
    end
    q = sa / sb;
    r = sa % sb;
    return {r[31:0], q[31:0]};
  endfunction

  // --------------------------------------------------
  // monitor and resp_rdy driver
  // --------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      cyc_q.delete();
      cycle = 0;
      req_count = 0;
      resp_count = 0;
    end else begin
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
          void'(cyc_q.pop_front());
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(ref_result(req_fn, req_a, req_b));
        cyc_q.push_back(cycle);
        req_count++;
      end
      cycle++;
    end
    exp_count = exp_q.size();
    if (exp_count > 0) begin
      exp_head = exp_q[0];
      head_cycle = cyc_q[0];
    end
    if (exp_count > max_depth) begin
      max_depth = exp_count;
    end
  end

  always @(negedge clk) begin
    case (rdy_mode)
      RDY_HOLD: resp_rdy = 1'b0;
      RDY_RANDOM: begin
        rdy_lfsr = lfsr_step(rdy_lfsr);
        resp_rdy = rdy_lfsr[0];
      end
      default: resp_rdy = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  a_reset_state : assert property (@(posedge clk) $fell(reset) |-> !resp_val && req_rdy)
    else begin
      err_count++;
      $display("** Error at %0d ns: resp_val high or req_rdy low after reset", $time);
    end

  // every response transfer must match the oldest outstanding request
  a_resp_match : assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (exp_count > 0 && resp_result == exp_head))
    else begin
      err_count++;
      $display("** Error at %0d ns: response %h, expected %h (%0d outstanding)",
               $time, $sampled(resp_result), $sampled(exp_head), $sampled(exp_count));
    end

  a_resp_stable : assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val && $stable(resp_result))
    else begin
      err_count++;
      $display("** Error at %0d ns: response changed or dropped while stalled", $time);
    end

  // valid after edge 34, so a transfer lands on edge 35 at the earliest
  a_min_latency : assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_count > 0) |-> (cycle - head_cycle >= 35))
    else begin
      err_count++;
      $display("** Error at %0d ns: response after only %0d cycles",
               $time, $sampled(cycle) - $sampled(head_cycle));
    end

  // --------------------------------------------------
  // stimulus tasks entered and left on a falling edge
  // --------------------------------------------------

  task automatic send_req(input div_pkg::div_fn_t fn, input div_pkg::operand_t a,
                          input div_pkg::operand_t b);
    req_fn = fn;
    req_a = a;
    req_b = b;
    req_val = 1'b1;
    // req_rdy depends on state only, settled since the rising edge
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic set_rdy_mode(input int mode);
    @(posedge clk);
    rdy_mode = mode;
    @(negedge clk);
  endtask

  task automatic drain();
    while (exp_count != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests_done++;
    $display("test %0d %s done, %0d errors", tests_done, name, err_count - mark);
  endtask

  task automatic reset_check();
    int mark;
    mark = err_count;
    @(negedge clk);
    report_test("reset state", mark);
  endtask

  task automatic unsigned_mix();
    int mark;
    div_pkg::operand_t a;
    div_pkg::operand_t b;
    mark = err_count;
    set_rdy_mode(RDY_RANDOM);
    send_req(div_pkg::FN_UNSIGNED, 32'd100, 32'd7);
    // dividend below divisor
    send_req(div_pkg::FN_UNSIGNED, 32'd5, 32'd9);
    send_req(div_pkg::FN_UNSIGNED, 32'hdead_beef, 32'd1);
    send_req(div_pkg::FN_UNSIGNED, 32'hffff_ffff, 32'hffff_ffff);
    send_req(div_pkg::FN_UNSIGNED, 32'hffff_ffff, 32'd2);
    for (int i = 0; i < N_RAND; i++) begin
      a = rand_word(32);
      // shifted divisor spreads the quotient sizes
      b = rand_word(32) >> rand_word(5);
      send_req(div_pkg::FN_UNSIGNED, a, b);
    end
    drain();
    report_test("unsigned", mark);
  endtask

  task automatic signed_mix();
    int mark;
    div_pkg::operand_t a;
    div_pkg::operand_t b;
    mark = err_count;
    send_req(div_pkg::FN_SIGNED, 32'd17, 32'd5);
    send_req(div_pkg::FN_SIGNED, -32'sd17, 32'd5);
    send_req(div_pkg::FN_SIGNED, 32'd17, -32'sd5);
    send_req(div_pkg::FN_SIGNED, -32'sd17, -32'sd5);
    send_req(div_pkg::FN_SIGNED, -32'sd1, 32'd2);
    for (int i = 0; i < N_RAND; i++) begin
      a = rand_word(32);
      b = rand_word(32) >> rand_word(5);
      if (rand_word(1)) begin
        b = -b;
      end
      send_req(div_pkg::FN_SIGNED, a, b);
    end
    drain();
    report_test("signed", mark);
  endtask

  task automatic corner_cases();
    int mark;
    mark = err_count;
    send_req(div_pkg::FN_UNSIGNED, 32'h0000_1234, 32'd0);
    send_req(div_pkg::FN_UNSIGNED, 32'd0, 32'd0);
    send_req(div_pkg::FN_SIGNED, -32'sd7, 32'd0);
    // most negative by -1 overflows
    send_req(div_pkg::FN_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_req(div_pkg::FN_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_req(div_pkg::FN_SIGNED, 32'h8000_0000, 32'd1);
    drain();
    report_test("zero divisor and overflow", mark);
  endtask

  task automatic backpressure_hold();
    int mark;
    mark = err_count;
    set_rdy_mode(RDY_HOLD);
    // one per stage fills the pipeline
    send_req(div_pkg::FN_UNSIGNED, 32'd1000, 32'd3);
    send_req(div_pkg::FN_SIGNED, -32'sd1000, 32'd3);
    send_req(div_pkg::FN_UNSIGNED, 32'h7777_7777, 32'd16);
    while (req_rdy) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    assert (!req_rdy && resp_val && exp_count == 3)
      else begin
        err_count++;
        $display("** Error at %0d ns: pipeline did not hold three divisions with req_rdy low",
                 $time);
      end
    set_rdy_mode(RDY_RANDOM);
    drain();
    report_test("back-pressure", mark);
  endtask

  task automatic streaming_burst();
    int mark;
    mark = err_count;
    set_rdy_mode(RDY_ALWAYS);
    max_depth = 0;
    for (int i = 0; i < 8; i++) begin
      send_req(div_pkg::div_fn_t'(rand_word(1)), rand_word(32), rand_word(32) >> rand_word(5));
    end
    drain();
    assert (max_depth >= 2)
      else begin
        err_count++;
        $display("back-to-back requests never overlapped in the pipeline");
      end
    report_test("streaming", mark);
  endtask

  // --------------------------------------------------
  // sequence and report
  // --------------------------------------------------

  initial begin
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = div_pkg::FN_UNSIGNED;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b1;
    rdy_mode = RDY_ALWAYS;
    max_depth = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_check();
    unsigned_mix();
    signed_mix();
    corner_cases();
    backpressure_hold();
    streaming_burst();
    assert (req_count == resp_count)
      else begin
        err_count++;
        $display("responses lost or duplicated: %0d requests, %0d responses",
                 req_count, resp_count);
      end
    $display("%0d tests, %0d requests, %0d responses, %0d errors",
             tests_done, req_count, resp_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- src/int_div_iterative.sv
// iterative 32-bit divider, signed and unsigned, val/rdy on both channels
// 34 cycles from request to response without back-pressure, up to three in flight
`timescale 1ns/1ps

module int_div_iterative (
  input  logic              clk,
  input  logic              reset,
  // request channel
  input  div_pkg::div_fn_t  req_fn,
  input  div_pkg::operand_t req_a,
  input  div_pkg::operand_t req_b,
  input  logic              req_val,
  output logic              req_rdy,
  // response channel, remainder in the upper word
  output div_pkg::result_t  resp_result,
  output logic              resp_val,
  input  logic              resp_rdy
);

  // request stage to core
  logic              opd_val;
  logic              opd_rdy;
  div_pkg::operand_t opd_a_mag;
  div_pkg::operand_t opd_b_mag;
  logic              opd_neg_quot;
  logic              opd_neg_rem;

  // control and datapath
  logic              load;
  logic              step;
  logic              count_zero;

  // core to response stage
  logic              raw_val;
  logic              raw_rdy;
  div_pkg::operand_t raw_quot;
  div_pkg::operand_t raw_rem;
  logic              raw_neg_quot;
  logic              raw_neg_rem;

  div_req_stage req0 (
    .clk          (clk),
    .reset        (reset),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .opd_val      (opd_val),
    .opd_rdy      (opd_rdy),
    .opd_a_mag    (opd_a_mag),
    .opd_b_mag    (opd_b_mag),
    .opd_neg_quot (opd_neg_quot),
    .opd_neg_rem  (opd_neg_rem)
  );

  div_iter_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .opd_val    (opd_val),
    .opd_rdy    (opd_rdy),
    .count_zero (count_zero),
    .raw_val    (raw_val),
    .raw_rdy    (raw_rdy),
    .load       (load),
    .step       (step)
  );

  div_iter_dpath dpath0 (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .step         (step),
    .opd_a_mag    (opd_a_mag),
    .opd_b_mag    (opd_b_mag),
    .opd_neg_quot (opd_neg_quot),
    .opd_neg_rem  (opd_neg_rem),
    .count_zero   (count_zero),
    .raw_quot     (raw_quot),
    .raw_rem      (raw_rem),
    .raw_neg_quot (raw_neg_quot),
    .raw_neg_rem  (raw_neg_rem)
  );

  div_resp_stage resp0 (
    .clk          (clk),
    .reset        (reset),
    .raw_val      (raw_val),
    .raw_rdy      (raw_rdy),
    .raw_quot     (raw_quot),
    .raw_rem      (raw_rem),
    .raw_neg_quot (raw_neg_quot),
    .raw_neg_rem  (raw_neg_rem),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

//--- src/div_resp_stage.sv
// output side: sign correction and a one-entry response register
// the entry stays put and unchanged while resp_rdy is low
`timescale 1ns/1ps

module div_resp_stage (
  input  logic              clk,
  input  logic              reset,
  // raw result from the core
  input  logic              raw_val,
  output logic              raw_rdy,
  input  div_pkg::operand_t raw_quot,
  input  div_pkg::operand_t raw_rem,
  input  logic              raw_neg_quot,
  input  logic              raw_neg_rem,
  // response channel
  output div_pkg::result_t  resp_result,
  output logic              resp_val,
  input  logic              resp_rdy
);

  logic              full;
  logic              raw_fire;
  div_pkg::operand_t quot_fix;
  div_pkg::operand_t rem_fix;

  // --------------------------------------------------
  // sign restore
  // --------------------------------------------------

  assign quot_fix = raw_neg_quot ? -raw_quot : raw_quot;
  assign rem_fix = raw_neg_rem ? -raw_rem : raw_rem;

  // --------------------------------------------------
  // response entry
  // --------------------------------------------------

  // room when empty or when the held response leaves this cycle
  assign raw_rdy = ~full | resp_rdy;
  assign raw_fire = raw_val & raw_rdy;
  assign resp_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (raw_fire) begin
      full <= 1'b1;
    end else if (resp_rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (raw_fire) begin
      resp_result <= {rem_fix, quot_fix};
    end
  end

  // response must not change or vanish while the consumer stalls
  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val && $stable(resp_result)
  );

endmodule

//--- src/div_iter_dpath.sv
// restoring shift-subtract datapath, one quotient bit per step
// results are magnitudes; the sign flags ride along for the output side
`timescale 1ns/1ps

module div_iter_dpath (
  input  logic              clk,
  input  logic              reset,
  // commands from control
  input  logic              load,
  input  logic              step,
  // operands from the request stage
  input  div_pkg::operand_t opd_a_mag,
  input  div_pkg::operand_t opd_b_mag,
  input  logic              opd_neg_quot,
  input  logic              opd_neg_rem,
  // status to control
  output logic              count_zero,
  // raw result towards the response stage
  output div_pkg::operand_t raw_quot,
  output div_pkg::operand_t raw_rem,
  output logic              raw_neg_quot,
  output logic              raw_neg_rem
);

  // partial remainder in [64:32], dividend then quotient bits in [31:0]
  // bit 64 catches the borrow of the trial subtraction
  logic [2*div_pkg::OPERAND_W:0] rq_reg;
  logic [2*div_pkg::OPERAND_W:0] rq_shift;
  logic [2*div_pkg::OPERAND_W:0] rq_diff;
  logic [2*div_pkg::OPERAND_W:0] rq_next;
  logic [2*div_pkg::OPERAND_W:0] divisor_ext;
  div_pkg::operand_t             divisor_reg;
  div_pkg::count_t               count_reg;
  logic                          borrow;

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------

  // divisor lined up with the upper word
  assign divisor_ext = {1'b0, divisor_reg, {div_pkg::OPERAND_W{1'b0}}};
  assign rq_shift = {rq_reg[2*div_pkg::OPERAND_W-1:0], 1'b0};
  assign rq_diff = rq_shift - divisor_ext;
  // negative difference means the divisor did not fit
  assign borrow = rq_diff[2*div_pkg::OPERAND_W];
  // keep difference and set the quotient bit, or restore the shifted value
  assign rq_next = borrow ? rq_shift : {rq_diff[2*div_pkg::OPERAND_W:1], 1'b1};

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_reg <= '0;
    end else if (load) begin
      count_reg <= div_pkg::COUNT_INIT;
    end else if (step) begin
      count_reg <= count_reg - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg <= {{(div_pkg::OPERAND_W + 1){1'b0}}, opd_a_mag};
      divisor_reg <= opd_b_mag;
      raw_neg_quot <= opd_neg_quot;
      raw_neg_rem <= opd_neg_rem;
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  assign count_zero = (count_reg == '0);
  assign raw_quot = rq_reg[div_pkg::OPERAND_W-1:0];
  assign raw_rem = rq_reg[2*div_pkg::OPERAND_W-1:div_pkg::OPERAND_W];

endmodule

//--- src/div_iter_ctrl.sv
// control FSM of the iterative divider core
// one division at a time; a new load waits until the result has left DONE
`timescale 1ns/1ps

module div_iter_ctrl (
  input  logic clk,
  input  logic reset,
  // operand side
  input  logic opd_val,
  output logic opd_rdy,
  // status from the datapath
  input  logic count_zero,
  // result side
  output logic raw_val,
  input  logic raw_rdy,
  // datapath commands
  output logic load,
  output logic step
);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_next;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::IDLE: begin
        // operands taken on this edge
        if (opd_val) begin
          state_next = div_pkg::CALC;
        end
      end
      div_pkg::CALC: begin
        // last step runs with the counter at zero
        if (count_zero) begin
          state_next = div_pkg::DONE;
        end
      end
      div_pkg::DONE: begin
        // hold the result until the output side takes it
        if (raw_rdy) begin
          state_next = div_pkg::IDLE;
        end
      end
      default: begin
        state_next = div_pkg::IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  // ready depends on state only, so no path from opd_val
  assign opd_rdy = (state == div_pkg::IDLE);
  assign load = opd_rdy & opd_val;
  // every CALC cycle is one shift-subtract
  assign step = (state == div_pkg::CALC);
  assign raw_val = (state == div_pkg::DONE);

  a_load_step_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(load && step)
  );

  // the datapath counter must end CALC after exactly DIV_STEPS steps
  a_step_count : assert property (
    @(posedge clk) disable iff (reset)
    load |=> (state == div_pkg::CALC) [*div_pkg::DIV_STEPS] ##1 (state == div_pkg::DONE)
  );

endmodule

//--- src/div_req_stage.sv
// one-entry request register in front of the divider core
// operands leave as magnitudes plus sign flags; unsigned requests never set the flags
`timescale 1ns/1ps

module div_req_stage (
  input  logic              clk,
  input  logic              reset,
  // request channel
  input  div_pkg::div_fn_t  req_fn,
  input  div_pkg::operand_t req_a,
  input  div_pkg::operand_t req_b,
  input  logic              req_val,
  output logic              req_rdy,
  // operands towards the core
  output logic              opd_val,
  input  logic              opd_rdy,
  output div_pkg::operand_t opd_a_mag,
  output div_pkg::operand_t opd_b_mag,
  output logic              opd_neg_quot,
  output logic              opd_neg_rem
);

  logic              full;
  logic              req_fire;
  logic              opd_fire;
  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic              b_zero;
  div_pkg::operand_t a_mag;
  div_pkg::operand_t b_mag;

  // --------------------------------------------------
  // operand unsigning
  // --------------------------------------------------

  assign is_signed = (req_fn == div_pkg::FN_SIGNED);
  // sign bits only count in signed mode
  assign a_neg = is_signed & req_a[div_pkg::OPERAND_W-1];
  assign b_neg = is_signed & req_b[div_pkg::OPERAND_W-1];
  assign b_zero = (req_b == '0);

  // most negative value maps to 2^31, still correct as an unsigned magnitude
  assign a_mag = a_neg ? -req_a : req_a;
  assign b_mag = b_neg ? -req_b : req_b;

  // --------------------------------------------------
  // handshakes and entry
  // --------------------------------------------------

  // accept when empty, or when the entry moves into the core this cycle
  assign req_rdy = ~full | opd_rdy;
  assign req_fire = req_val & req_rdy;
  assign opd_fire = full & opd_rdy;
  assign opd_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (req_fire) begin
      full <= 1'b1;
    end else if (opd_fire) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      opd_a_mag <= a_mag;
      opd_b_mag <= b_mag;
      // zero divisor keeps the all-ones quotient unnegated
      opd_neg_quot <= (a_neg ^ b_neg) & ~b_zero;
      // remainder follows the dividend sign
      opd_neg_rem <= a_neg;
    end
  end

  // a stalled entry must not change under the core
  a_opd_hold : assert property (
    @(posedge clk) disable iff (reset)
    (opd_val && !opd_rdy) |=> opd_val && $stable(opd_a_mag) && $stable(opd_b_mag)
      && $stable(opd_neg_quot) && $stable(opd_neg_rem)
  );

endmodule

//--- src/div_pkg.sv
// shared types and constants for the iterative integer divider
// widths are fixed at 32-bit operands and a 64-bit {remainder, quotient} result

package div_pkg;

  // --------------------------------------------------
  // widths and step count
  // --------------------------------------------------

  // operand and magnitude width
  localparam int OPERAND_W = 32;
  // response carries remainder and quotient side by side
  localparam int RESULT_W = 2 * OPERAND_W;
  // one quotient bit is produced per step
  localparam int DIV_STEPS = 32;
  localparam int COUNT_W = $clog2(DIV_STEPS);

  // --------------------------------------------------
  // types
  // --------------------------------------------------

  // one data word, raw operand or unsigned magnitude
  typedef logic [OPERAND_W-1:0] operand_t;
  // remainder in [63:32], quotient in [31:0]
  typedef logic [RESULT_W-1:0] result_t;
  // function select on the request channel
  typedef logic div_fn_t;
  // counts the steps still to go in the core
  typedef logic [COUNT_W-1:0] count_t;

  // function codes
  localparam div_fn_t FN_UNSIGNED = 1'b0;
  localparam div_fn_t FN_SIGNED = 1'b1;

  // counter value after load, reaches zero on the last step
  localparam count_t COUNT_INIT = count_t'(DIV_STEPS - 1);

  // core sequencing
  //   IDLE  waiting for operands
  //   CALC  shift-subtract steps
  //   DONE  raw result waiting for the output side
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

endpackage
